/* logic/bbox_pkg.sv */
/*
 * Shared widths and packet types for the rasterizer bounding-box stage.
 * Coordinates are signed fixed point with radix fraction bits.
 * Modules import this package inside their body and use scoped names on ports.
 * The testbench uses the same types to build stimulus and expected results.
 */
`default_nettype none

package bbox_pkg;

    // Bits per coordinate and color channel
    localparam int sigfig = 24;
    // Fraction bits, the rest is the integer part
    localparam int radix = 10;
    // Register stages between input and output
    localparam int pipe_depth = 3;

    // Signed fixed-point coordinate
    typedef logic signed [sigfig-1:0] fixed_t;
    // Unsigned color channel
    typedef logic [sigfig-1:0] color_t;

    // One vertex, z rides along but is not used for the box
    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vertex_t;

    // Three vertices of one triangle, index 0 is vertex a
    typedef vertex_t [2:0] tri_t;
    // Three color channels
    typedef color_t [2:0] rgb_t;

    // Box corner or screen size
    typedef struct packed {
        fixed_t x;
        fixed_t y;
    } point_t;

    // Lower-left and upper-right corners
    typedef struct packed {
        point_t ll;
        point_t ur;
    } box_t;

    // One-hot sub-sample code
    // 1000 one sample, 0100 half pixel, 0010 quarter pixel, 0001 eighth pixel
    typedef logic [3:0] msaa_t;

    // Input word
    typedef struct packed {
        tri_t verts;
        rgb_t color;
        logic valid;
    } tri_pkt_t;

    // Result word, triangle and color travel with the clamped box
    typedef struct packed {
        tri_t verts;
        rgb_t color;
        box_t box;
        logic valid;
    } box_pkt_t;

endpackage

`default_nettype wire

/* logic/bbox_extent.sv */
/*
 * Finds the axis-aligned box around a triangle and floors its corners
 * to the sub-sample grid selected by the one-hot MSAA code.
 * Purely combinational; feeds the screen clipper.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_extent (
    input  bbox_pkg::tri_t  tri_in,
    input  bbox_pkg::msaa_t msaa,
    output bbox_pkg::box_t  snapped
);
    import bbox_pkg::*;

    // Raw min/max box before flooring
    box_t raw;
    // Fraction bits that survive the floor
    logic [radix-1:0] frac_mask;

    // Smallest of three signed values, ties resolve to any equal value
    function automatic fixed_t min3(input fixed_t a, input fixed_t b, input fixed_t c);
        fixed_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    // Largest of three signed values
    function automatic fixed_t max3(input fixed_t a, input fixed_t b, input fixed_t c);
        fixed_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // Clearing low bits of a two's complement value rounds toward minus infinity
    function automatic fixed_t floor_fix(input fixed_t v, input logic [radix-1:0] mask);
        return {v[sigfig-1:radix], v[radix-1:0] & mask};
    endfunction

    // Direct min/max, so equal coordinates need no special case
    always_comb begin
        raw.ll.x = min3(tri_in[0].x, tri_in[1].x, tri_in[2].x);
        raw.ll.y = min3(tri_in[0].y, tri_in[1].y, tri_in[2].y);
        raw.ur.x = max3(tri_in[0].x, tri_in[1].x, tri_in[2].x);
        raw.ur.y = max3(tri_in[0].y, tri_in[1].y, tri_in[2].y);
    end

    // Keep the top 0 to 3 fraction bits
    always_comb begin
        case (msaa)
            4'b1000: frac_mask = '0;
            4'b0100: frac_mask = {1'b1, {(radix-1){1'b0}}};
            4'b0010: frac_mask = {2'b11, {(radix-2){1'b0}}};
            // Eighth pixel, also the finest grid for a code that is not one-hot
            default: frac_mask = {3'b111, {(radix-3){1'b0}}};
        endcase
    end

    // Both corners floor the same way
    always_comb begin
        snapped.ll.x = floor_fix(raw.ll.x, frac_mask);
        snapped.ll.y = floor_fix(raw.ll.y, frac_mask);
        snapped.ur.x = floor_fix(raw.ur.x, frac_mask);
        snapped.ur.y = floor_fix(raw.ur.y, frac_mask);
    end

endmodule

`default_nettype wire

/* logic/bbox_screen_clip.sv */
/*
 * Clamps the snapped box to the screen rectangle from the origin to the
 * screen corner and drops triangles whose box lies wholly off-screen.
 * Packs triangle, color, clamped box and valid into the result word.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_screen_clip (
    input  bbox_pkg::tri_pkt_t pkt,
    input  bbox_pkg::box_t     snapped,
    input  bbox_pkg::point_t   screen,
    output bbox_pkg::box_pkt_t result
);
    import bbox_pkg::*;

    // Box lies completely outside the screen
    logic off_screen;
    // Per-edge rejection terms
    logic past_right;
    logic past_top;
    logic before_left;
    logic before_bottom;
    // Clamped corners
    box_t clamped;

    // Lower bound at zero
    function automatic fixed_t at_least_zero(input fixed_t v);
        return (v < 0) ? fixed_t'(0) : v;
    endfunction

    // Upper bound at the screen edge
    function automatic fixed_t at_most(input fixed_t v, input fixed_t limit);
        return (v > limit) ? limit : v;
    endfunction

    // Rejection uses the unclamped box
    always_comb begin
        past_right    = snapped.ll.x > screen.x;
        past_top      = snapped.ll.y > screen.y;
        before_left   = snapped.ur.x < 0;
        before_bottom = snapped.ur.y < 0;
        off_screen    = past_right | past_top | before_left | before_bottom;
    end

    // ll pulled up to the origin, ur pulled down to the screen corner
    always_comb begin
        clamped.ll.x = at_least_zero(snapped.ll.x);
        clamped.ll.y = at_least_zero(snapped.ll.y);
        clamped.ur.x = at_most(snapped.ur.x, screen.x);
        clamped.ur.y = at_most(snapped.ur.y, screen.y);
    end

    // Triangle and color pass untouched
    always_comb begin
        result.verts = pkt.verts;
        result.color = pkt.color;
        result.box   = clamped;
        // An invalid input stays invalid whatever its box
        result.valid = pkt.valid & ~off_screen;
    end

endmodule

`default_nettype wire

/* logic/bbox_pipe.sv */
/*
 * Register pipeline for the result word.
 * All stages advance together on edges with halt low and hold while halt
 * is high. Latency is depth advancing edges; works for any depth of one or more.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_pipe #(
    parameter int depth = bbox_pkg::pipe_depth
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               halt,
    input  bbox_pkg::box_pkt_t d,
    output bbox_pkg::box_pkt_t q
);
    import bbox_pkg::*;

    // Stage 0 takes the input, stage depth-1 drives the output
    box_pkt_t stage [depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            // Clear everything so no stale valid or payload leaks out
            for (int i = 0; i < depth; i++) begin
                stage[i] <= '0;
            end
        end else if (!halt) begin
            stage[0] <= d;
            // Shift the rest by one
            for (int i = 1; i < depth; i++) begin
                stage[i] <= stage[i-1];
            end
        end
        // Halt high holds every stage
    end

    assign q = stage[depth-1];

endmodule

`default_nettype wire

/* logic/bbox_top.sv */
/*
 * Bounding-box stage top level.
 * A triangle, screen size and MSAA code sampled on an edge with halt low
 * come out as a clamped box on box_out pipe_depth advancing edges later.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               halt,
    input  bbox_pkg::tri_pkt_t tri_in,
    input  bbox_pkg::point_t   screen,
    input  bbox_pkg::msaa_t    msaa,
    output bbox_pkg::box_pkt_t box_out
);
    import bbox_pkg::*;

    // Floored min/max box
    box_t     snapped;
    // Clamped result before the registers
    box_pkt_t clipped;

    // Extent and floor
    bbox_extent u_extent (
        .tri_in  (tri_in.verts),
        .msaa    (msaa),
        .snapped (snapped)
    );

    // Screen clamp and reject
    bbox_screen_clip u_clip (
        .pkt     (tri_in),
        .snapped (snapped),
        .screen  (screen),
        .result  (clipped)
    );

    // Halt-frozen registers
    bbox_pipe #(
        .depth (pipe_depth)
    ) u_pipe (
        .clk   (clk),
        .reset (reset),
        .halt  (halt),
        .d     (clipped),
        .q     (box_out)
    );

endmodule

`default_nettype wire

/* verif/bbox_chk.sv */
/*
 * Concurrent assertions on the bounding-box stage outputs.
 * Bound into every bbox_top instance; failures are counted for the testbench.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_chk (
    input logic               clk,
    input logic               reset,
    input logic               halt,
    input bbox_pkg::point_t   screen,
    input bbox_pkg::box_pkt_t box_out
);
    import bbox_pkg::*;

    int fail_count = 0;
    // Screen size travelling alongside each item in the pipeline
    point_t screen_pipe [pipe_depth];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < pipe_depth; i++) begin
                screen_pipe[i] <= '0;
            end
        end else if (!halt) begin
            screen_pipe[0] <= screen;
            for (int i = 1; i < pipe_depth; i++) begin
                screen_pipe[i] <= screen_pipe[i-1];
            end
        end
    end

    // Corners in order
    ll_not_above_ur: assert property (@(posedge clk) disable iff (reset)
        box_out.valid |-> (box_out.box.ll.x <= box_out.box.ur.x) &&
                          (box_out.box.ll.y <= box_out.box.ur.y))
        else begin
            $error("Valid box has ll beyond ur");
            fail_count++;
        end

    // Box inside the screen that came with the triangle
    box_on_screen: assert property (@(posedge clk) disable iff (reset)
        box_out.valid |-> (box_out.box.ur.x <= screen_pipe[pipe_depth-1].x) &&
                          (box_out.box.ur.y <= screen_pipe[pipe_depth-1].y) &&
                          (box_out.box.ll.x >= 0) && (box_out.box.ll.y >= 0))
        else begin
            $error("Valid box reaches outside the screen");
            fail_count++;
        end

    no_valid_after_reset: assert property (@(posedge clk) reset |=> !box_out.valid)
        else begin
            $error("Output valid high right after a reset edge");
            fail_count++;
        end

    hold_on_halt: assert property (@(posedge clk) disable iff (reset)
        halt |=> $stable(box_out))
        else begin
            $error("Output changed across a halted edge");
            fail_count++;
        end

endmodule

bind bbox_top bbox_chk u_chk (
    .clk     (clk),
    .reset   (reset),
    .halt    (halt),
    .screen  (screen),
    .box_out (box_out)
);

`default_nettype wire

/* verif/bbox_monitor.sv */
/*
 * Scoreboard for the bounding-box stage.
 * Queues the expected result on every advancing edge and compares box_out
 * with the queue head once the pipeline has filled. Counts all errors.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_monitor (
    input  logic               clk,
    input  logic               reset,
    input  logic               halt,
    input  bbox_pkg::box_pkt_t exp_pkt,
    input  bbox_pkg::box_pkt_t box_out,
    output int                 error_count
);
    import bbox_pkg::*;

    // Expected results in input order
    box_pkt_t expected_q [$];
    // Advancing edges since reset
    int advances = 0;
    int errors = 0;

    assign error_count = errors;

    task automatic check_word(input string name, input logic [sigfig-1:0] got,
                              input logic [sigfig-1:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic compare_result(input box_pkt_t exp);
        if (exp.valid && box_out.valid !== 1'b1) begin
            $display("Expected valid result missing from the output at %0t", $time);
            errors++;
        end else if (!exp.valid && box_out.valid !== 1'b0) begin
            $display("Unexpected valid output at %0t where the slot should be empty", $time);
            errors++;
        end else if (exp.valid) begin
            // Box and payload only matter for a valid slot
            check_word("box_out.box.ll.x", box_out.box.ll.x, exp.box.ll.x);
            check_word("box_out.box.ll.y", box_out.box.ll.y, exp.box.ll.y);
            check_word("box_out.box.ur.x", box_out.box.ur.x, exp.box.ur.x);
            check_word("box_out.box.ur.y", box_out.box.ur.y, exp.box.ur.y);
            for (int v = 0; v < 3; v++) begin
                check_word($sformatf("box_out.verts[%0d].x", v),
                           box_out.verts[v].x, exp.verts[v].x);
                check_word($sformatf("box_out.verts[%0d].y", v),
                           box_out.verts[v].y, exp.verts[v].y);
                check_word($sformatf("box_out.verts[%0d].z", v),
                           box_out.verts[v].z, exp.verts[v].z);
                check_word($sformatf("box_out.color[%0d]", v),
                           box_out.color[v], exp.color[v]);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            advances = 0;
            expected_q.delete();
        end else if (!halt) begin
            // box_out now holds the item sampled depth advances ago
            if (advances >= pipe_depth) begin
                compare_result(expected_q.pop_front());
            end else if (box_out.valid !== 1'b0) begin
                $display("Valid output at %0t before any input could reach it", $time);
                errors++;
            end
            expected_q.push_back(exp_pkt);
            advances++;
        end
        // Halted edges neither sample nor move anything
    end

endmodule

`default_nettype wire

/* verif/bbox_tb.sv */
/*
 * Testbench for the bounding-box stage.
 * Plays every vector from verif/bbox_vectors.txt twice, first back to back,
 * then with a random halt, and hands the expected result to the monitor.
 */
`timescale 1ns/1ps
`default_nettype none

module bbox_tb;
    import bbox_pkg::*;

    // Vector layout in 24-bit words
    localparam int words_per_vec = 21;
    localparam int w_color = 9;
    localparam int w_valid = 12;
    localparam int w_screen = 13;
    localparam int w_msaa = 15;
    localparam int w_box = 16;
    localparam int w_exp_valid = 20;
    localparam int max_vec = 64;

    logic     clk;
    logic     reset;
    logic     halt;
    tri_pkt_t tri_in;
    point_t   screen;
    msaa_t    msaa;
    box_pkt_t box_out;
    // Expected result for the vector now on the inputs
    box_pkt_t exp_pkt;

    logic [sigfig-1:0] vec_mem [0:max_vec*words_per_vec-1];
    int      n_vec = 0;
    int      load_errors = 0;
    int      mon_errors;
    int      total_errors;
    integer  seed;
    longint  limit_ns;

    bbox_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .halt    (halt),
        .tri_in  (tri_in),
        .screen  (screen),
        .msaa    (msaa),
        .box_out (box_out)
    );

    bbox_monitor u_mon (
        .clk         (clk),
        .reset       (reset),
        .halt        (halt),
        .exp_pkt     (exp_pkt),
        .box_out     (box_out),
        .error_count (mon_errors)
    );

    always #10 clk = ~clk;

    task automatic load_vectors();
        for (int i = 0; i < max_vec * words_per_vec; i++) begin
            vec_mem[i] = 'x;
        end
        $readmemh("verif/bbox_vectors.txt", vec_mem);
        // Count tests until the first unfilled slot
        while (n_vec < max_vec &&
               !$isunknown(vec_mem[n_vec * words_per_vec + w_exp_valid])) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            $display("No vectors could be read from verif/bbox_vectors.txt");
            load_errors++;
        end
    endtask

    // Puts one vector and its expected result on the bus
    task automatic apply_vector(input int idx);
        tri_pkt_t t;
        box_pkt_t e;
        point_t   s;
        int       b;
        b = idx * words_per_vec;
        for (int v = 0; v < 3; v++) begin
            t.verts[v].x = vec_mem[b + 3*v];
            t.verts[v].y = vec_mem[b + 3*v + 1];
            t.verts[v].z = vec_mem[b + 3*v + 2];
            t.color[v] = vec_mem[b + w_color + v];
        end
        t.valid = vec_mem[b + w_valid][0];
        s.x = vec_mem[b + w_screen];
        s.y = vec_mem[b + w_screen + 1];
        e.verts = t.verts;
        e.color = t.color;
        e.box.ll.x = vec_mem[b + w_box];
        e.box.ll.y = vec_mem[b + w_box + 1];
        e.box.ur.x = vec_mem[b + w_box + 2];
        e.box.ur.y = vec_mem[b + w_box + 3];
        e.valid = vec_mem[b + w_exp_valid][0];
        tri_in <= t;
        screen <= s;
        msaa <= vec_mem[b + w_msaa][3:0];
        exp_pkt <= e;
    endtask

    // Empty slot, nothing valid expected
    task automatic apply_idle();
        tri_in <= '0;
        exp_pkt <= '0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        halt = 1'b0;
        tri_in = '0;
        screen = '0;
        msaa = 4'b1000;
        exp_pkt = '0;
        seed = 32'h0278_55ab;
        load_vectors();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // Back to back with halt low
        for (int i = 0; i < n_vec; i++) begin
            apply_vector(i);
            @(posedge clk);
        end
        // Same stream again with roughly one halted edge in four
        for (int i = 0; i < n_vec; i++) begin
            while (($random(seed) & 3) == 0) begin
                halt <= 1'b1;
                @(posedge clk);
            end
            halt <= 1'b0;
            apply_vector(i);
            @(posedge clk);
        end
        halt <= 1'b0;
        apply_idle();
        repeat (pipe_depth + 2) @(posedge clk);
        @(negedge clk);
        total_errors = load_errors + mon_errors + i_dut.u_chk.fail_count;
        $display("Errors: %0d load, %0d monitor, %0d assertion",
                 load_errors, mon_errors, i_dut.u_chk.fail_count);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Each vector is presented twice, once per phase
    initial begin
        wait (n_vec > 0);
        limit_ns = (2 * n_vec + 16) * 4 * 20;
        #(limit_ns);
        $display("Watchdog expired after %0d ns with vectors still pending", limit_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/bbox_pkg.sv
logic/bbox_extent.sv
logic/bbox_screen_clip.sv
logic/bbox_pipe.sv
logic/bbox_top.sv
verif/bbox_chk.sv
verif/bbox_monitor.sv
verif/bbox_tb.sv

/* verif/bbox_vectors.txt */
// ax ay az bx by bz cx cy cz r g b valid scr_x scr_y msaa ll_x ll_y ur_x ur_y exp_valid
// One triangle per line, 24-bit hex words, negative coordinates in two's complement
2b00 5200 400 7900 1780 800 3c00 a080 c00 ff ff00 ff0000 1 a0000 78000 8 2800 1400 7800 a000 1
3200 3200 0 3200 7800 0 6700 3200 0 10 20 30 1 a0000 78000 8 3000 3000 6400 7800 1
1d00 e00 0 1d00 2400 0 1d00 e00 0 1 2 3 1 a0000 78000 8 1c00 c00 1c00 2400 1
193c0 c940 400 1e2c0 11b40 400 1b840 f240 400 aa bb cc 1 a0000 78000 8 19000 c800 1e000 11800 1
193c0 c940 400 1e2c0 11b40 400 1b840 f240 400 aa bb cc 1 a0000 78000 4 19200 c800 1e200 11a00 1
193c0 c940 400 1e2c0 11b40 400 1b840 f240 400 aa bb cc 1 a0000 78000 2 19300 c900 1e200 11b00 1
193c0 c940 400 1e2c0 11b40 400 1b840 f240 400 aa bb cc 1 a0000 78000 1 19380 c900 1e280 11b00 1
193c0 c940 400 1e2c0 11b40 400 1b840 f240 400 aa bb cc 1 a0000 78000 6 19380 c900 1e280 11b00 1
ffea00 fff300 0 5000 2b00 0 2000 fffc00 0 11 22 33 1 a0000 78000 8 0 0 5000 2800 1
9da00 75900 0 a2b00 76c00 0 9ec00 7aa00 0 44 55 66 1 a0000 78000 8 9d800 75800 a0000 78000 1
ffd800 ffd800 0 af000 ffd800 0 ffd800 7d000 0 77 88 99 1 a0000 78000 4 0 0 a0000 78000 1
a0000 19000 0 a5000 1b800 0 a2800 1e000 0 1 1 1 1 a0000 78000 8 a0000 19000 a0000 1e000 1
a0200 2800 0 af000 5000 0 a1400 3c00 0 2 2 2 1 a0000 78000 8 a0000 2800 a0000 5000 1
ffb000 2800 0 ffea00 5000 0 fffb00 3c00 0 3 3 3 1 a0000 78000 8 0 0 0 0 0
2800 ffb000 0 5000 ffec00 0 3c00 fffe00 0 4 4 4 1 a0000 78000 8 0 0 0 0 0
a0400 2800 0 af000 5000 0 a2a00 3c00 0 5 5 5 1 a0000 78000 8 0 0 0 0 0
2800 78400 0 5000 7d000 0 3c00 7a800 0 6 6 6 1 a0000 78000 8 0 0 0 0 0
2b00 5200 400 7900 1780 800 3c00 a080 c00 ff ff00 ff0000 0 a0000 78000 8 2800 1400 7800 a000 0
